// File: compile.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_unit.sv
src/instr_queue.sv
src/extension_unit.sv
src/decode_stage.sv
src/front_end.sv
verif/front_end_chk.sv
verif/front_end_tb.sv

// File: Bender.yml
package:
  name: front_end

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/isa_pkg.sv
      - src/pipe_pkg.sv
      - src/fetch_unit.sv
      - src/instr_queue.sv
      - src/extension_unit.sv
      - src/decode_stage.sv
      - src/front_end.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/front_end_chk.sv
      - verif/front_end_tb.sv

// File: verif/front_end_tb.sv
`timescale 1ns/10ps

`include "cpu_defines.svh"

module front_end_tb;

   // about 320 words at most. hold duty stretches that well past 1000 cycles.
   localparam int CYCLE_LIMIT = 4000;

   logic                   clk;
   logic                   arst_n;
   logic                   instr_valid;
   logic [`CPU_WORD_W-1:0] instr;
   logic                   dec_hold;
   logic                   fetch_stall;
   logic                   dec_valid;
   logic [`CPU_WORD_W-1:0] dec_pc;
   logic [4:0]             dec_opcode;
   logic [2:0]             dec_rs;
   logic [2:0]             dec_rt;
   logic [2:0]             dec_rd;
   logic [`CPU_WORD_W-1:0] dec_imm;
   isa_pkg::imm_kind_e     dec_imm_kind;

   integer                 seed = 32'h14bb;
   int                     cycle_count = 0;
   string                  test_name = "none";
   int                     test_errors = 0;
   int                     error_count = 0;
   int                     tests_run = 0;
   int                     tests_failed = 0;
   int                     sent_count = 0;
   int                     decoded_count = 0;
   logic [`CPU_WORD_W-1:0] model_pc = `PC_RESET;
   // expected entries in strobe order as {pc, word}.
   logic [31:0]            exp_q[$];

   front_end i_front_end (
      .clk          (clk),
      .arst_n       (arst_n),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .dec_hold     (dec_hold),
      .fetch_stall  (fetch_stall),
      .dec_valid    (dec_valid),
      .dec_pc       (dec_pc),
      .dec_opcode   (dec_opcode),
      .dec_rs       (dec_rs),
      .dec_rt       (dec_rt),
      .dec_rd       (dec_rd),
      .dec_imm      (dec_imm),
      .dec_imm_kind (dec_imm_kind)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reference model for the immediate table.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic isa_pkg::imm_kind_e expected_kind(input logic [4:0] op);
      case (op)
         isa_pkg::op_j, isa_pkg::op_jal:     return isa_pkg::imm_sign11;
         isa_pkg::op_addi, isa_pkg::op_subi: return isa_pkg::imm_sign5;
         isa_pkg::op_xori, isa_pkg::op_andni: return isa_pkg::imm_zero5;
         isa_pkg::op_lbi, isa_pkg::op_jr, isa_pkg::op_jalr,
         isa_pkg::op_beqz, isa_pkg::op_bnez,
         isa_pkg::op_bltz, isa_pkg::op_bgez: return isa_pkg::imm_sign8;
         isa_pkg::op_slbi:                   return isa_pkg::imm_zero8;
         default:                            return isa_pkg::imm_sign5;
      endcase
   endfunction

   function automatic logic [15:0] expected_imm(input logic [15:0] w,
                                                input isa_pkg::imm_kind_e kind);
      case (kind)
         isa_pkg::imm_sign11: return {{5{w[10]}}, w[10:0]};
         isa_pkg::imm_sign8:  return {{8{w[7]}}, w[7:0]};
         isa_pkg::imm_zero8:  return {8'h00, w[7:0]};
         isa_pkg::imm_zero5:  return {11'h000, w[4:0]};
         default:             return {{11{w[4]}}, w[4:0]};
      endcase
   endfunction

   // the 21 opcodes of the table by index.
   function automatic logic [4:0] table_opcode(input int idx);
      case (idx)
         0:       return isa_pkg::op_addi;
         1:       return isa_pkg::op_subi;
         2:       return isa_pkg::op_xori;
         3:       return isa_pkg::op_andni;
         4:       return isa_pkg::op_roli;
         5:       return isa_pkg::op_slli;
         6:       return isa_pkg::op_rori;
         7:       return isa_pkg::op_srli;
         8:       return isa_pkg::op_st;
         9:       return isa_pkg::op_ld;
         10:      return isa_pkg::op_stu;
         11:      return isa_pkg::op_beqz;
         12:      return isa_pkg::op_bnez;
         13:      return isa_pkg::op_bltz;
         14:      return isa_pkg::op_bgez;
         15:      return isa_pkg::op_lbi;
         16:      return isa_pkg::op_slbi;
         17:      return isa_pkg::op_j;
         18:      return isa_pkg::op_jr;
         19:      return isa_pkg::op_jal;
         default: return isa_pkg::op_jalr;
      endcase
   endfunction

   task automatic compare_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED test=%s %s expected=%0h actual=%0h",
                  test_name, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s passed", test_name);
      end else begin
         $display("test %s failed with %0d errors", test_name, test_errors);
         tests_failed++;
      end
      error_count += test_errors;
      test_errors = 0;
   endtask

   task automatic idle_cycle();
      instr_valid = 1'b0;
      @(posedge clk);
      #2;
   endtask

   // one strobe that enters the model as it is sent.
   task automatic send_word(input logic [15:0] word);
      while (fetch_stall) begin
         idle_cycle();
      end
      instr_valid = 1'b1;
      instr = word;
      exp_q.push_back({model_pc, word});
      model_pc += `PC_STEP;
      sent_count++;
      @(posedge clk);
      #2;
      instr_valid = 1'b0;
   endtask

   task automatic drain_queue();
      dec_hold = 1'b0;
      while (exp_q.size() != 0) begin
         idle_cycle();
      end
   endtask

   // decoded outputs are stable at the falling edge.
   always @(negedge clk) begin
      logic [31:0]        entry;
      isa_pkg::imm_kind_e kind;
      if (arst_n && dec_valid) begin
         decoded_count++;
         if (exp_q.size() == 0) begin
            $display("ERROR test=%s: decode produced a word that was never sent", test_name);
            test_errors++;
         end else begin
            entry = exp_q.pop_front();
            kind = expected_kind(entry[15:11]);
            compare_value("pc", entry[31:16], dec_pc);
            compare_value("opcode", entry[15:11], dec_opcode);
            compare_value("rs", entry[10:8], dec_rs);
            compare_value("rt", entry[7:5], dec_rt);
            compare_value("rd", entry[4:2], dec_rd);
            compare_value("imm", expected_imm(entry[15:0], kind), dec_imm);
            compare_value("kind", 32'(kind), 32'(dec_imm_kind));
         end
      end
   end

   initial begin
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: decode outputs stopped arriving");
      $display("STATUS: FAIL");
      $finish;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      logic [31:0] rnd;
      logic [4:0]  op;
      logic        stall_seen;
      int          waited;
      arst_n = 1'b0;
      instr_valid = 1'b0;
      instr = '0;
      dec_hold = 1'b0;
      repeat (3) @(posedge clk);
      #2 arst_n = 1'b1;

      start_test("reset");
      compare_value("dec_valid", 0, dec_valid);
      compare_value("fetch_stall", 0, fetch_stall);
      idle_cycle();
      compare_value("dec_valid", 0, dec_valid);
      finish_test();

      // one word into an empty queue takes two edges from capture to output.
      start_test("latency");
      instr_valid = 1'b1;
      instr = {isa_pkg::op_addi, 3'd5, 3'd2, 5'b10110};
      exp_q.push_back({model_pc, instr});
      model_pc += `PC_STEP;
      sent_count++;
      @(posedge clk);
      #2 instr_valid = 1'b0;
      waited = 0;
      while (!dec_valid && waited < 10) begin
         @(posedge clk);
         #2;
         waited++;
      end
      if (!dec_valid) begin
         $display("ERROR test=%s: no decode output after a single strobe", test_name);
         test_errors++;
      end
      compare_value("cycles", 2, waited);
      compare_value("first pc", `PC_RESET, dec_pc);
      drain_queue();
      finish_test();

      // every opcode with immediate sign bits set and then clear.
      start_test("extension");
      for (int i = 0; i < 21; i++) begin
         rnd = $random(seed);
         send_word({table_opcode(i), rnd[10:0] | 11'b100_1001_0000});
         send_word({table_opcode(i), rnd[10:0] & 11'b011_0110_1111});
      end
      drain_queue();
      finish_test();

      start_test("random");
      for (int i = 0; i < 250; i++) begin
         rnd = $random(seed);
         if (rnd[7:5] == 3'd0) begin
            dec_hold = !dec_hold;
         end
         op = rnd[4] ? table_opcode(rnd[12:8] % 21) : rnd[20:16];
         if (rnd[1:0] != 2'd0 && !fetch_stall) begin
            send_word({op, rnd[31:21]});
         end else begin
            idle_cycle();
         end
      end
      drain_queue();
      finish_test();

      // hold long enough to fill the queue.
      start_test("backpressure");
      dec_hold = 1'b1;
      stall_seen = 1'b0;
      repeat (20) begin
         rnd = $random(seed);
         if (fetch_stall) begin
            stall_seen = 1'b1;
            idle_cycle();
         end else begin
            send_word(rnd[15:0]);
         end
      end
      drain_queue();
      compare_value("stall seen", 1, stall_seen);
      compare_value("decoded words", sent_count, decoded_count);
      finish_test();

      start_test("assertions");
      compare_value("failures", 0, i_front_end.i_front_end_chk.fail_count);
      finish_test();

      $display("tests run %0d, failed %0d, errors %0d, words %0d",
               tests_run, tests_failed, error_count, decoded_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: verif/front_end_chk.sv
`timescale 1ns/10ps

module front_end_chk (
   input logic clk,
   input logic arst_n,
   input logic push,
   input logic queue_full,
   input logic pop,
   input logic empty,
   input logic dec_hold,
   input logic dec_valid
);

   // failed assertions so far, read by the testbench at the end.
   int fail_count = 0;

   // the fetch register never pushes into a full queue.
   push_into_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !queue_full)
      else begin
         fail_count++;
         $error("push while the instruction queue is full");
      end

   // decode never pops an empty queue.
   pop_from_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
      else begin
         fail_count++;
         $error("pop while the instruction queue is empty");
      end

   // a decoded word means hold was low on its pop edge.
   valid_after_hold: assert property (@(posedge clk) disable iff (!arst_n)
                                      dec_valid |-> !$past(dec_hold))
      else begin
         fail_count++;
         $error("decode output after a held pop edge");
      end

endmodule

bind front_end front_end_chk i_front_end_chk (
   .clk        (clk),
   .arst_n     (arst_n),
   .push       (push),
   .queue_full (i_instr_queue.full),
   .pop        (pop),
   .empty      (empty),
   .dec_hold   (dec_hold),
   .dec_valid  (dec_valid)
);

// File: src/front_end.sv
`timescale 1ns/10ps

`include "cpu_defines.svh"

module front_end (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   instr_valid,
   input  logic [`CPU_WORD_W-1:0] instr,
   input  logic                   dec_hold,
   output logic                   fetch_stall,
   output logic                   dec_valid,
   output logic [`CPU_WORD_W-1:0] dec_pc,
   output logic [4:0]             dec_opcode,
   output logic [2:0]             dec_rs,
   output logic [2:0]             dec_rt,
   output logic [2:0]             dec_rd,
   output logic [`CPU_WORD_W-1:0] dec_imm,
   output isa_pkg::imm_kind_e     dec_imm_kind
);

   // fetch to queue.
   logic                   push;
   pipe_pkg::fetch_entry_t push_entry;
   logic                   nearly_full;

   // queue to decode.
   logic                   pop;
   logic                   empty;
   pipe_pkg::fetch_entry_t head_entry;

   fetch_unit i_fetch_unit (
      .clk         (clk),
      .arst_n      (arst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .nearly_full (nearly_full),
      .push        (push),
      .push_entry  (push_entry),
      .fetch_stall (fetch_stall)
   );

   instr_queue i_instr_queue (
      .clk         (clk),
      .arst_n      (arst_n),
      .push        (push),
      .push_entry  (push_entry),
      .pop         (pop),
      .head_entry  (head_entry),
      .empty       (empty),
      .nearly_full (nearly_full)
   );

   decode_stage i_decode_stage (
      .clk          (clk),
      .arst_n       (arst_n),
      .head_entry   (head_entry),
      .empty        (empty),
      .dec_hold     (dec_hold),
      .pop          (pop),
      .dec_valid    (dec_valid),
      .dec_pc       (dec_pc),
      .dec_opcode   (dec_opcode),
      .dec_rs       (dec_rs),
      .dec_rt       (dec_rt),
      .dec_rd       (dec_rd),
      .dec_imm      (dec_imm),
      .dec_imm_kind (dec_imm_kind)
   );

endmodule

// File: src/decode_stage.sv
`timescale 1ns/10ps

`include "cpu_defines.svh"

module decode_stage (
   input  logic                   clk,
   input  logic                   arst_n,
   input  pipe_pkg::fetch_entry_t head_entry,
   input  logic                   empty,
   input  logic                   dec_hold,
   output logic                   pop,
   output logic                   dec_valid,
   output logic [`CPU_WORD_W-1:0] dec_pc,
   output logic [4:0]             dec_opcode,
   output logic [2:0]             dec_rs,
   output logic [2:0]             dec_rt,
   output logic [2:0]             dec_rd,
   output logic [`CPU_WORD_W-1:0] dec_imm,
   output isa_pkg::imm_kind_e     dec_imm_kind
);

   logic [`CPU_WORD_W-1:0] head_imm;
   isa_pkg::imm_kind_e     head_imm_kind;

   // take the head whenever there is one and nothing holds us.
   assign pop = !empty && !dec_hold;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // immediate of the head word.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   extension_unit i_extension_unit (
      .instr    (head_entry.instr),
      .immed    (head_imm),
      .imm_kind (head_imm_kind)
   );

   // one valid pulse per pop.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= pop;
      end
   end

   // decoded fields, loaded on the pop edge.
   always_ff @(posedge clk) begin
      if (pop) begin
         dec_pc       <= head_entry.pc;
         dec_opcode   <= head_entry.instr[15:11];
         dec_rs       <= head_entry.instr[10:8];
         dec_rt       <= head_entry.instr[7:5];
         dec_rd       <= head_entry.instr[4:2];
         dec_imm      <= head_imm;
         dec_imm_kind <= head_imm_kind;
      end
   end

endmodule

// File: src/extension_unit.sv
`timescale 1ns/10ps

`include "cpu_defines.svh"

module extension_unit (
   input  logic [`CPU_WORD_W-1:0] instr,
   output logic [`CPU_WORD_W-1:0] immed,
   output isa_pkg::imm_kind_e     imm_kind
);

   logic [4:0]          opcode;
   logic                zero_ext;
   isa_pkg::instr_fmt_e fmt;

   assign opcode = instr[15:11];

   // only these three take the field unsigned.
   assign zero_ext = (opcode == isa_pkg::op_xori) ||
                     (opcode == isa_pkg::op_andni) ||
                     (opcode == isa_pkg::op_slbi);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // opcode to immediate field width.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      case (opcode)
         isa_pkg::op_addi, isa_pkg::op_subi,
         isa_pkg::op_xori, isa_pkg::op_andni,
         isa_pkg::op_roli, isa_pkg::op_slli,
         isa_pkg::op_rori, isa_pkg::op_srli,
         isa_pkg::op_st, isa_pkg::op_ld, isa_pkg::op_stu:  fmt = isa_pkg::fmt_i1;
         isa_pkg::op_beqz, isa_pkg::op_bnez,
         isa_pkg::op_bltz, isa_pkg::op_bgez,
         isa_pkg::op_lbi, isa_pkg::op_slbi,
         isa_pkg::op_jr, isa_pkg::op_jalr:                  fmt = isa_pkg::fmt_i2;
         isa_pkg::op_j, isa_pkg::op_jal:                    fmt = isa_pkg::fmt_j;
         default:                                           fmt = isa_pkg::fmt_r;
      endcase
   end

   // extension by format and signedness.
   always_comb begin
      immed    = '0;
      imm_kind = isa_pkg::imm_none;
      case (fmt)
         isa_pkg::fmt_j: begin
            immed    = {{5{instr[10]}}, instr[10:0]};
            imm_kind = isa_pkg::imm_sign11;
         end
         isa_pkg::fmt_i2: begin
            immed    = {{8{instr[7] && !zero_ext}}, instr[7:0]};
            imm_kind = zero_ext ? isa_pkg::imm_zero8 : isa_pkg::imm_sign8;
         end
         // shifts, rotates, loads, stores and the rest.
         default: begin
            immed    = {{11{instr[4] && !zero_ext}}, instr[4:0]};
            imm_kind = zero_ext ? isa_pkg::imm_zero5 : isa_pkg::imm_sign5;
         end
      endcase
   end

endmodule

// File: src/instr_queue.sv
`timescale 1ns/10ps

`include "cpu_defines.svh"

module instr_queue (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   push,
   input  pipe_pkg::fetch_entry_t push_entry,
   input  logic                   pop,
   output pipe_pkg::fetch_entry_t head_entry,
   output logic                   empty,
   output logic                   nearly_full
);

   localparam int PTR_W = $clog2(`IQ_DEPTH);
   localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

   pipe_pkg::fetch_entry_t mem [`IQ_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             do_push;
   logic             do_pop;

   assign full        = (count == CNT_W'(`IQ_DEPTH));
   assign empty       = (count == '0);
   // one slot kept back for the word sitting in the fetch register.
   assign nearly_full = (count >= CNT_W'(`IQ_DEPTH - 1));

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // head is valid whenever empty is low.
   assign head_entry = mem[rd_ptr];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // pointers and occupancy.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leaves the count alone.
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // storage.
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_entry;
      end
   end

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/10ps

`include "cpu_defines.svh"

module fetch_unit (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   instr_valid,
   input  logic [`CPU_WORD_W-1:0] instr,
   input  logic                   nearly_full,
   output logic                   push,
   output pipe_pkg::fetch_entry_t push_entry,
   output logic                   fetch_stall
);

   logic [`CPU_WORD_W-1:0] pc_q;
   logic                   accept;

   // a strobe is only taken while the queue has room for it.
   assign accept      = instr_valid && !nearly_full;
   assign fetch_stall = nearly_full;

   // program counter and push strobe.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc_q <= `PC_RESET;
         push <= 1'b0;
      end else begin
         push <= accept;
         if (accept) begin
            pc_q <= pc_q + `CPU_WORD_W'(`PC_STEP);
         end
      end
   end

   // capture register, tagged with the pc of this word.
   always_ff @(posedge clk) begin
      if (accept) begin
         push_entry.pc    <= pc_q;
         push_entry.instr <= instr;
      end
   end

endmodule

// File: src/pipe_pkg.sv
`include "cpu_defines.svh"

package pipe_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // entries passed from fetch through the queue to decode.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // one fetched word tagged with its address.
   typedef struct packed {
      // address of the word.
      logic [`CPU_WORD_W-1:0] pc;
      // raw instruction word.
      logic [`CPU_WORD_W-1:0] instr;
   } fetch_entry_t;

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // opcodes, bits 15..11 of the word.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // 5-bit immediate group.
   localparam logic [4:0] op_addi  = 5'b01000;
   localparam logic [4:0] op_subi  = 5'b01001;
   localparam logic [4:0] op_xori  = 5'b01010;
   localparam logic [4:0] op_andni = 5'b01011;
   localparam logic [4:0] op_roli  = 5'b10100;
   localparam logic [4:0] op_slli  = 5'b10101;
   localparam logic [4:0] op_rori  = 5'b10110;
   localparam logic [4:0] op_srli  = 5'b10111;
   localparam logic [4:0] op_st    = 5'b10000;
   localparam logic [4:0] op_ld    = 5'b10001;
   localparam logic [4:0] op_stu   = 5'b10011;

   // branches and byte loads.
   localparam logic [4:0] op_beqz  = 5'b01100;
   localparam logic [4:0] op_bnez  = 5'b01101;
   localparam logic [4:0] op_bltz  = 5'b01110;
   localparam logic [4:0] op_bgez  = 5'b01111;
   localparam logic [4:0] op_lbi   = 5'b11000;
   localparam logic [4:0] op_slbi  = 5'b10010;

   // jumps.
   localparam logic [4:0] op_j     = 5'b00100;
   localparam logic [4:0] op_jr    = 5'b00101;
   localparam logic [4:0] op_jal   = 5'b00110;
   localparam logic [4:0] op_jalr  = 5'b00111;

   // format by width of the immediate field.
   typedef enum logic [1:0] {
      fmt_r,
      fmt_i1,
      fmt_i2,
      fmt_j
   } instr_fmt_e;

   // rule used to form the 16-bit immediate.
   typedef enum logic [2:0] {
      imm_none,
      imm_sign5,
      imm_zero5,
      imm_sign8,
      imm_zero8,
      imm_sign11
   } imm_kind_e;

endpackage

// File: src/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// front end sizing.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// instruction word and immediate width.
`define CPU_WORD_W 16

// instruction queue entries.
`define IQ_DEPTH 8

// program counter after reset.
`define PC_RESET 16'h0000

// pc advance per fetched word, in bytes.
`define PC_STEP 2

`endif
